// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = frontend_tb
FILELIST = all.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: all.f
src/ib_pkg.sv
src/fetch_aligner.sv
src/instr_buffer.sv
src/dual_issue_sel.sv
src/frontend_top.sv
dv/frontend_checker.sv
dv/frontend_tb.sv

// File: dv/frontend_checker.sv
`timescale 1ns/10ps

module frontend_checker (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          flush,
  input  logic [ib_pkg::POP_W-1:0]      pop_num,
  input  logic [ib_pkg::IB_CNT_W-1:0]   ib_count
);

  import ib_pkg::*;

  // ##################################################
  // occupancy
  // ##################################################

  count_in_range: assert property (
    @(posedge clk) disable iff (reset)
      int'(ib_count) <= IB_DEPTH
  ) else $error("ib_count is above the buffer depth");

  // the selector may only pop what the buffer holds
  pop_within_count: assert property (
    @(posedge clk) disable iff (reset)
      int'(pop_num) <= int'(ib_count)
  ) else $error("pop_num is larger than the occupancy");

  // ##################################################
  // flush
  // ##################################################

  flush_empties: assert property (
    @(posedge clk) disable iff (reset)
      flush |=> (ib_count == '0)
  ) else $error("ib_count is not zero after a flush");

endmodule

// File: dv/frontend_tb.sv
`timescale 1ns/10ps

module frontend_tb;

  import ib_pkg::*;

  logic                         clk;
  logic                         reset;
  logic                         flush;
  logic                         fetch_valid;
  logic [FETCH_W*INSTR_W-1:0]   fetch_block;
  logic [FETCH_OFS_W-1:0]       fetch_offset;
  logic                         issue_stall;
  logic                         fetch_ready;
  logic                         issue_valid0;
  logic [INSTR_W-1:0]           issue_instr0;
  logic                         issue_valid1;
  logic [INSTR_W-1:0]           issue_instr1;
  logic [IB_CNT_W-1:0]          ib_count;

  // model of the buffer contents with the next instruction to issue at the front
  logic [INSTR_W-1:0] model_q[$];

  integer seed;
  int     seq_num;
  int     out_of_reset;
  int     valid_pct;
  int     stall_pct;
  int     stall_max;
  int     stall_left;
  int     flush_pct;
  int     branch_pct;
  bit     took_block;
  int     accepted_total;
  int     issued_total;
  int     dropped_total;
  int     offset_hits [FETCH_W];
  int     prev_count;
  bit     prev_stall;
  bit     prev_flush;

  frontend_top uut (
    .clk          (clk),
    .reset        (reset),
    .flush        (flush),
    .fetch_valid  (fetch_valid),
    .fetch_block  (fetch_block),
    .fetch_offset (fetch_offset),
    .issue_stall  (issue_stall),
    .fetch_ready  (fetch_ready),
    .issue_valid0 (issue_valid0),
    .issue_instr0 (issue_instr0),
    .issue_valid1 (issue_valid1),
    .issue_instr1 (issue_instr1),
    .ib_count     (ib_count)
  );

  bind instr_buffer frontend_checker u_checker (
    .clk      (clk),
    .reset    (reset),
    .flush    (flush),
    .pop_num  (pop_num),
    .ib_count (ib_count)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // ##################################################
  // reference model
  // ##################################################

  function automatic bit exp_ready(int held, logic [FETCH_OFS_W-1:0] ofs, bit started);
    return started && ((IB_DEPTH - held) >= (FETCH_W - int'(ofs)));
  endfunction

  // lanes ofs..3 of an accepted block join the back of the model
  function automatic void pack_block(logic [FETCH_W*INSTR_W-1:0] blk,
                                     logic [FETCH_OFS_W-1:0] ofs);
    for (int i = int'(ofs); i < FETCH_W; i++) begin
      model_q.push_back(blk[i*INSTR_W +: INSTR_W]);
    end
  endfunction

  function automatic bit chance(int pct);
    return ($unsigned($random(seed)) % 100) < pct;
  endfunction

  // sequence number above the opcode
  function automatic logic [INSTR_W-1:0] make_instr(int num, bit is_branch);
    logic [OPC_W-1:0] opc;
    opc = is_branch ? OPC_BRANCH : 7'b011_0011;
    return {num[INSTR_W-OPC_W-1:0], opc};
  endfunction

  task automatic stop_on_error(string msg);
    $display("CHECK FAILED at %0d ns: %s", $time, msg);
    $display("Test failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic stop_on_timeout(string what);
    $display("Timed out at %0d ns while waiting for %s", $time, what);
    $display("Test failed");
    $fatal(1, "stopped on a timeout");
  endtask

  // ##################################################
  // compare process
  // ##################################################

  // outputs are sampled mid-cycle and the model then steps to the coming edge
  always @(negedge clk) begin : compare
    int n_pop;
    bit exp_v0;
    bit exp_v1;
    bit exp_rdy;
    if (reset) begin
      out_of_reset = 0;
      model_q.delete();
      took_block = 1'b0;
      prev_stall = 1'b0;
      prev_flush = 1'b0;
    end else begin
      out_of_reset = out_of_reset + 1;
      assert (int'(ib_count) == model_q.size())
        else stop_on_error($sformatf("ib_count %0d, model holds %0d",
                                     ib_count, model_q.size()));
      if (prev_flush) begin
        assert (int'(ib_count) == 0)
          else stop_on_error("ib_count not zero after flush");
      end
      if (prev_stall && !prev_flush) begin
        assert (int'(ib_count) >= prev_count)
          else stop_on_error("ib_count decreased during a stall");
      end
      // aligner is held off for one cycle after reset release
      exp_rdy = exp_ready(model_q.size(), fetch_offset, out_of_reset > 1);
      assert (fetch_ready == exp_rdy)
        else stop_on_error($sformatf("fetch_ready %0b, expected %0b", fetch_ready, exp_rdy));
      exp_v0 = !issue_stall && (model_q.size() >= 1);
      exp_v1 = 1'b0;
      if (exp_v0 && model_q.size() >= 2) begin
        exp_v1 = (model_q[0][OPC_W-1:0] != OPC_BRANCH);
      end
      assert (issue_valid0 == exp_v0)
        else stop_on_error($sformatf("issue_valid0 %0b, expected %0b", issue_valid0, exp_v0));
      assert (issue_valid1 == exp_v1)
        else stop_on_error($sformatf("issue_valid1 %0b, expected %0b", issue_valid1, exp_v1));
      if (exp_v0) begin
        assert (issue_instr0 == model_q[0])
          else stop_on_error($sformatf("issue_instr0 %h, expected %h",
                                       issue_instr0, model_q[0]));
      end
      if (exp_v1) begin
        assert (issue_instr1 == model_q[1])
          else stop_on_error($sformatf("issue_instr1 %h, expected %h",
                                       issue_instr1, model_q[1]));
      end
      n_pop = int'(exp_v0) + int'(exp_v1);
      took_block = fetch_valid && fetch_ready;
      if (flush) begin
        dropped_total = dropped_total + model_q.size();
        model_q.delete();
      end else begin
        for (int k = 0; k < n_pop; k++) begin
          void'(model_q.pop_front());
        end
        issued_total = issued_total + int'(issue_valid0) + int'(issue_valid1);
        if (took_block) begin
          accepted_total = accepted_total + FETCH_W - int'(fetch_offset);
          offset_hits[fetch_offset] = offset_hits[fetch_offset] + 1;
          pack_block(fetch_block, fetch_offset);
        end
      end
      prev_count = int'(ib_count);
      prev_stall = issue_stall;
      prev_flush = flush;
    end
  end

  // ##################################################
  // stimulus
  // ##################################################

  task automatic new_block();
    for (int i = 0; i < FETCH_W; i++) begin
      fetch_block[i*INSTR_W +: INSTR_W] = make_instr(seq_num, chance(branch_pct));
      seq_num = seq_num + 1;
    end
    fetch_offset = FETCH_OFS_W'($unsigned($random(seed)) % FETCH_W);
  endtask

  // an offered block stays on the inputs until it is taken
  task automatic drive_cycles(int cycles);
    for (int c = 0; c < cycles; c++) begin
      @(posedge clk);
      #1;
      if (!fetch_valid || took_block) begin
        fetch_valid = chance(valid_pct);
        if (fetch_valid) begin
          new_block();
        end
      end
      if (stall_left > 0) begin
        stall_left = stall_left - 1;
        issue_stall = 1'b1;
      end else if (chance(stall_pct)) begin
        stall_left = int'($unsigned($random(seed)) % stall_max);
        issue_stall = 1'b1;
      end else begin
        issue_stall = 1'b0;
      end
      flush = chance(flush_pct);
    end
  endtask

  task automatic await_ready(int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (!fetch_ready) begin
      if (n >= limit) stop_on_timeout("fetch_ready after reset");
      n = n + 1;
      @(negedge clk);
    end
  endtask

  // stall until fetch backs up and flush the full buffer
  task automatic fill_and_flush(int limit);
    int n;
    n = 0;
    valid_pct = 100;
    stall_pct = 100;
    stall_max = 1;
    flush_pct = 0;
    drive_cycles(1);
    @(negedge clk);
    while (fetch_ready) begin
      if (n >= limit) stop_on_timeout("the buffer to fill");
      n = n + 1;
      drive_cycles(1);
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
    issue_stall = 1'b0;
    stall_left = 0;
    @(negedge clk);
    assert (int'(ib_count) == 0 && !issue_valid0 && !issue_valid1)
      else stop_on_error("buffer not empty or still issuing after flush");
  endtask

  task automatic drain(int limit);
    int n;
    n = 0;
    valid_pct = 0;
    stall_pct = 0;
    stall_left = 0;
    flush_pct = 0;
    drive_cycles(1);
    @(negedge clk);
    while (fetch_valid || int'(ib_count) != 0) begin
      if (n >= limit) stop_on_timeout("the buffer to drain");
      n = n + 1;
      drive_cycles(1);
      @(negedge clk);
    end
  endtask

  initial begin
    seed = 32'h4258_4e0a;
    reset = 1'b1;
    flush = 1'b0;
    fetch_valid = 1'b0;
    fetch_block = '0;
    fetch_offset = '0;
    issue_stall = 1'b0;
    seq_num = 0;
    stall_left = 0;
    accepted_total = 0;
    issued_total = 0;
    dropped_total = 0;
    for (int i = 0; i < FETCH_W; i++) begin
      offset_hits[i] = 0;
    end
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    await_ready(5);
    assert (int'(ib_count) == 0 && !issue_valid0 && !issue_valid1)
      else stop_on_error("state after reset is not empty");

    // plain traffic
    valid_pct = 80;
    stall_pct = 10;
    stall_max = 2;
    flush_pct = 0;
    branch_pct = 25;
    drive_cycles(400);

    // back-pressure with long stalls
    valid_pct = 100;
    stall_pct = 30;
    stall_max = 40;
    drive_cycles(400);

    // random flushes
    valid_pct = 80;
    stall_pct = 15;
    stall_max = 6;
    flush_pct = 4;
    drive_cycles(300);

    fill_and_flush(50);
    drain(200);

    @(posedge clk);
    #1;
    assert (model_q.size() == 0)
      else stop_on_error("model still holds instructions after drain");
    assert (accepted_total == issued_total + dropped_total)
      else stop_on_error($sformatf("accepted %0d, issued %0d, flushed %0d",
                                   accepted_total, issued_total, dropped_total));
    for (int i = 0; i < FETCH_W; i++) begin
      assert (offset_hits[i] > 0)
        else stop_on_error($sformatf("no block accepted at offset %0d", i));
    end
    $display("Test passed");
    $finish;
  end

endmodule

// File: src/dual_issue_sel.sv
`timescale 1ns/10ps

module dual_issue_sel (
  input  logic                           issue_stall,
  input  logic [ib_pkg::IB_DATA_W-1:0]   head0,
  input  logic [ib_pkg::IB_DATA_W-1:0]   head1,
  input  logic [ib_pkg::IB_CNT_W-1:0]    ib_count,
  output logic                           issue_valid0,
  output logic                           issue_valid1,
  output logic [ib_pkg::INSTR_W-1:0]     issue_instr0,
  output logic [ib_pkg::INSTR_W-1:0]     issue_instr1,
  output logic [ib_pkg::POP_W-1:0]       pop_num
);

  import ib_pkg::*;

  logic             has_one;
  logic             has_two;
  logic             head0_branch;
  logic             slot0_ok;
  logic             slot1_ok;

  // ##################################################
  // slot qualification
  // ##################################################

  assign has_one = (ib_count >= IB_CNT_W'(1));
  assign has_two = (ib_count >= IB_CNT_W'(2));

  // a control transfer in slot 0 goes alone
  assign head0_branch = (head0[OPC_W-1:0] == OPC_BRANCH);

  assign slot0_ok = has_one && head0[IB_DATA_W-1];
  assign slot1_ok = has_two && head1[IB_DATA_W-1] && !head0_branch;

  // stall holds everything in the buffer
  assign issue_valid0 = !issue_stall && slot0_ok;
  assign issue_valid1 = issue_valid0 && slot1_ok;

  // ##################################################
  // issue outputs
  // ##################################################

  // strip the valid bit
  assign issue_instr0 = head0[INSTR_W-1:0];
  assign issue_instr1 = head1[INSTR_W-1:0];

  // one pop per issued slot, slot 1 never issues without slot 0
  assign pop_num = POP_W'(issue_valid0) + POP_W'(issue_valid1);

endmodule

// File: src/fetch_aligner.sv
`timescale 1ns/10ps

module fetch_aligner (
  input  logic                                          clk,
  input  logic                                          reset,
  input  logic                                          fetch_valid,
  input  logic [ib_pkg::FETCH_W*ib_pkg::INSTR_W-1:0]    fetch_block,
  input  logic [ib_pkg::FETCH_OFS_W-1:0]                fetch_offset,
  input  logic [ib_pkg::IB_CNT_W-1:0]                   ib_count,
  output logic                                          fetch_ready,
  output logic [ib_pkg::PUSH_W-1:0]                     push_num,
  output logic [ib_pkg::FETCH_W*ib_pkg::IB_DATA_W-1:0]  push_group
);

  import ib_pkg::*;

  logic                            run;
  logic [FETCH_W*INSTR_W-1:0]      block_shift;
  logic [PUSH_W-1:0]               group_size;
  logic [IB_CNT_W-1:0]             free_space;
  logic                            take;

  // ##################################################
  // start-up gate
  // ##################################################

  // stays low through reset and the first cycle after release,
  // then sticks high so the buffer never sees a push while it clears
  always_ff @(posedge clk) begin
    if (reset) begin
      run <= 1'b0;
    end else begin
      run <= 1'b1;
    end
  end

  // ##################################################
  // lane packing
  // ##################################################

  // drop the lanes below the offset, lane fetch_offset lands in lane 0
  assign block_shift = fetch_block >> (INSTR_W * int'(fetch_offset));

  always_comb begin
    for (int i = 0; i < FETCH_W; i++) begin
      push_group[i*IB_DATA_W +: IB_DATA_W] = {1'b1, block_shift[i*INSTR_W +: INSTR_W]};
    end
  end

  // ##################################################
  // space check
  // ##################################################

  // lanes offset..3 are useful
  assign group_size = PUSH_W'(FETCH_W) - PUSH_W'(fetch_offset);

  // registered count only, a pop this cycle frees space next cycle
  assign free_space = IB_CNT_W'(IB_DEPTH) - ib_count;

  assign fetch_ready = run && (free_space >= IB_CNT_W'(group_size));

  assign take = fetch_valid && fetch_ready;

  // nothing pushed unless the block is taken at this edge
  assign push_num = take ? group_size : '0;

endmodule

// File: src/frontend_top.sv
`timescale 1ns/10ps

module frontend_top (
  input  logic                                        clk,
  input  logic                                        reset,
  input  logic                                        flush,
  input  logic                                        fetch_valid,
  input  logic [ib_pkg::FETCH_W*ib_pkg::INSTR_W-1:0]  fetch_block,
  input  logic [ib_pkg::FETCH_OFS_W-1:0]              fetch_offset,
  input  logic                                        issue_stall,
  output logic                                        fetch_ready,
  output logic                                        issue_valid0,
  output logic [ib_pkg::INSTR_W-1:0]                  issue_instr0,
  output logic                                        issue_valid1,
  output logic [ib_pkg::INSTR_W-1:0]                  issue_instr1,
  output logic [ib_pkg::IB_CNT_W-1:0]                 ib_count
);

  import ib_pkg::*;

  logic [PUSH_W-1:0]            push_num;
  logic [FETCH_W*IB_DATA_W-1:0] push_group;
  logic [POP_W-1:0]             pop_num;
  logic [IB_DATA_W-1:0]         head0;
  logic [IB_DATA_W-1:0]         head1;

  fetch_aligner u_aligner (
    .clk          (clk),
    .reset        (reset),
    .fetch_valid  (fetch_valid),
    .fetch_block  (fetch_block),
    .fetch_offset (fetch_offset),
    .ib_count     (ib_count),
    .fetch_ready  (fetch_ready),
    .push_num     (push_num),
    .push_group   (push_group)
  );

  instr_buffer u_buffer (
    .clk        (clk),
    .reset      (reset),
    .flush      (flush),
    .push_num   (push_num),
    .push_group (push_group),
    .pop_num    (pop_num),
    .head0      (head0),
    .head1      (head1),
    .ib_count   (ib_count)
  );

  dual_issue_sel u_issue (
    .issue_stall  (issue_stall),
    .head0        (head0),
    .head1        (head1),
    .ib_count     (ib_count),
    .issue_valid0 (issue_valid0),
    .issue_valid1 (issue_valid1),
    .issue_instr0 (issue_instr0),
    .issue_instr1 (issue_instr1),
    .pop_num      (pop_num)
  );

endmodule

// File: src/ib_pkg.sv
package ib_pkg;

  // ##################################################
  // instruction and opcode
  // ##################################################

  localparam int INSTR_W = 32;
  localparam int OPC_W   = 7;

  // conditional branch major opcode, bits 6:0
  localparam logic [OPC_W-1:0] OPC_BRANCH = 7'b110_0011;

  // ##################################################
  // instruction buffer
  // ##################################################

  // top bit of an entry is its valid bit
  localparam int IB_DATA_W = INSTR_W + 1;
  localparam int IB_DEPTH  = 16;
  localparam int IB_PTR_W  = 4;
  localparam int IB_CNT_W  = IB_PTR_W + 1;

  // ##################################################
  // fetch and issue widths
  // ##################################################

  localparam int FETCH_W     = 4;
  localparam int FETCH_OFS_W = 2;

  // push count 0..4, pop count 0..2
  localparam int PUSH_W = 3;
  localparam int POP_W  = 2;

endpackage

// File: src/instr_buffer.sv
`timescale 1ns/10ps

module instr_buffer (
  input  logic                                          clk,
  input  logic                                          reset,
  input  logic                                          flush,
  input  logic [ib_pkg::PUSH_W-1:0]                     push_num,
  input  logic [ib_pkg::FETCH_W*ib_pkg::IB_DATA_W-1:0]  push_group,
  input  logic [ib_pkg::POP_W-1:0]                      pop_num,
  output logic [ib_pkg::IB_DATA_W-1:0]                  head0,
  output logic [ib_pkg::IB_DATA_W-1:0]                  head1,
  output logic [ib_pkg::IB_CNT_W-1:0]                   ib_count
);

  import ib_pkg::*;

  logic [IB_DATA_W-1:0] mem [IB_DEPTH];
  logic [IB_PTR_W-1:0]  head_ptr;
  logic [IB_PTR_W-1:0]  tail_ptr;
  logic                 drop;

  // a flush throws away whatever is pushed or popped in its cycle
  assign drop = reset || flush;

  // ##################################################
  // pointers and occupancy
  // ##################################################

  // pointers are IB_PTR_W wide and wrap on their own at IB_DEPTH
  always_ff @(posedge clk) begin
    if (drop) begin
      head_ptr <= '0;
      tail_ptr <= '0;
    end else begin
      tail_ptr <= tail_ptr + IB_PTR_W'(push_num);
      head_ptr <= head_ptr + IB_PTR_W'(pop_num);
    end
  end

  always_ff @(posedge clk) begin
    if (drop) begin
      ib_count <= '0;
    end else begin
      ib_count <= ib_count + IB_CNT_W'(push_num) - IB_CNT_W'(pop_num);
    end
  end

  // ##################################################
  // storage
  // ##################################################

  // popped entries lose their valid bit
  // pushes land on free slots only, so the two never hit the same entry
  always_ff @(posedge clk) begin
    if (!drop) begin
      for (int j = 0; j < 2; j++) begin
        if (j < int'(pop_num)) begin
          mem[head_ptr + IB_PTR_W'(j)][IB_DATA_W-1] <= 1'b0;
        end
      end
      for (int i = 0; i < FETCH_W; i++) begin
        if (i < int'(push_num)) begin
          mem[tail_ptr + IB_PTR_W'(i)] <= push_group[i*IB_DATA_W +: IB_DATA_W];
        end
      end
    end
  end

  // ##################################################
  // read ports
  // ##################################################

  // contents are only meaningful up to ib_count, the selector checks that
  assign head0 = mem[head_ptr];
  assign head1 = mem[head_ptr + IB_PTR_W'(1)];

endmodule
